/* hdl/fcpu_pkg.sv */
`default_nettype none

package fcpu_pkg;

   localparam int DATA_W      = 32;
   localparam int GMEM_ADDR_W = 32;
   localparam int RSV_ID_W    = 4;

   // Memory operations accepted on the issue port
   typedef enum logic [1:0] {
      OP_LW  = 2'd0,
      OP_SW  = 2'd1,
      OP_LBU = 2'd2,
      OP_SB  = 2'd3
   } mem_op_t;

   // Configuration register select
   typedef enum logic [1:0] {
      REG_CTRL   = 2'd0,
      REG_BASE   = 2'd1,
      REG_LIMIT  = 2'd2,
      REG_FAULTS = 2'd3
   } cfg_addr_t;

   // Bit 0 of REG_CTRL
   localparam int CTRL_XLAT_EN_BIT = 0;

   typedef struct packed {
      logic [RSV_ID_W-1:0] rsv_id;
      mem_op_t             opcode;
      logic [DATA_W-1:0]   addr;
      logic [DATA_W-1:0]   data;
   } mem_req_t;

   typedef struct packed {
      logic [RSV_ID_W-1:0] rsv_id;
      logic [DATA_W-1:0]   data;
      logic                fault;
   } cdb_t;

   localparam int CDB_W = $bits(cdb_t);

endpackage

`default_nettype wire

/* hdl/op_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module op_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  DEPTH     = 4
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     push,
   input  payload_t push_data,
   output logic     full,
   input  logic     pop,
   output payload_t pop_data,
   output logic     empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign full     = (count == CNT_W'(DEPTH));
   assign empty    = (count == '0);
   assign do_push  = push && !full;
   assign do_pop   = pop && !empty;
   assign pop_data = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Producers and consumers must respect the flags
   a_no_overflow: assert property (
      @(posedge clk) disable iff (!arst_n) push |-> !full
   );

   a_no_underflow: assert property (
      @(posedge clk) disable iff (!arst_n) pop |-> !empty
   );

endmodule

`default_nettype wire

/* hdl/mmu_cfg_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module mmu_cfg_regs
   import fcpu_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   cfg_we,
   input  cfg_addr_t              cfg_addr,
   input  logic [DATA_W-1:0]      cfg_wdata,
   input  logic                   fault_pulse,
   output logic [DATA_W-1:0]      cfg_rdata,
   output logic [GMEM_ADDR_W-1:0] seg_base,
   output logic [DATA_W-1:0]      seg_limit,
   output logic                   xlat_en
);

   logic [DATA_W-1:0] fault_cnt;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         xlat_en   <= 1'b0;
         seg_base  <= '0;
         seg_limit <= '0;
      end else if (cfg_we) begin
         case (cfg_addr)
            REG_CTRL:  xlat_en   <= cfg_wdata[CTRL_XLAT_EN_BIT];
            REG_BASE:  seg_base  <= GMEM_ADDR_W'(cfg_wdata);
            REG_LIMIT: seg_limit <= cfg_wdata;
            default:   ;
         endcase
      end
   end

   // Clear on write wins over a simultaneous fault
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fault_cnt <= '0;
      end else if (cfg_we && cfg_addr == REG_FAULTS) begin
         fault_cnt <= '0;
      end else if (fault_pulse && fault_cnt != '1) begin
         fault_cnt <= fault_cnt + 1'b1;
      end
   end

   always_comb begin
      cfg_rdata = '0;
      case (cfg_addr)
         REG_CTRL:   cfg_rdata[CTRL_XLAT_EN_BIT] = xlat_en;
         REG_BASE:   cfg_rdata = DATA_W'(seg_base);
         REG_LIMIT:  cfg_rdata = seg_limit;
         REG_FAULTS: cfg_rdata = fault_cnt;
         default:    cfg_rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

/* hdl/address_translator.sv */
`timescale 1ns/100ps
`default_nettype none

module address_translator
   import fcpu_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   in_valid,
   input  mem_req_t               in_req,
   input  logic [GMEM_ADDR_W-1:0] seg_base,
   input  logic [DATA_W-1:0]      seg_limit,
   input  logic                   xlat_en,
   input  logic                   stall,
   output logic                   out_valid,
   output mem_req_t               out_req,
   output logic [GMEM_ADDR_W-1:0] out_paddr,
   output logic                   out_fault
);

   logic                   advance;
   logic                   is_word;
   logic                   misaligned;
   logic                   over_limit;
   logic [GMEM_ADDR_W-1:0] paddr;

   // Stage moves when empty or when downstream takes the current entry
   assign advance = !out_valid || !stall;

   assign is_word    = (in_req.opcode == OP_LW) || (in_req.opcode == OP_SW);
   assign misaligned = is_word && (in_req.addr[1:0] != 2'b00);
   assign over_limit = xlat_en && (in_req.addr >= seg_limit);
   assign paddr      = xlat_en ? seg_base + GMEM_ADDR_W'(in_req.addr)
                               : GMEM_ADDR_W'(in_req.addr);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else if (advance) begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (advance && in_valid) begin
         out_req   <= in_req;
         out_paddr <= paddr;
         out_fault <= misaligned || over_limit;
      end
   end

endmodule

`default_nettype wire

/* hdl/memory_management_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module memory_management_unit
   import fcpu_pkg::*;
#(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                   clk,
   input  logic                   arst_n,
   // Issue port
   input  logic [RSV_ID_W-1:0]    rsv_id,
   input  logic                   valid,
   input  mem_op_t                opcode,
   input  logic [DATA_W-1:0]      address,
   input  logic [DATA_W-1:0]      data,
   output logic                   ready,
   // CDB port
   output logic [RSV_ID_W-1:0]    cdb_rsv_id,
   output logic [DATA_W-1:0]      cdb_data,
   output logic                   cdb_fault,
   output logic                   cdb_valid,
   input  logic                   cdb_ready,
   // Segment configuration
   input  logic [GMEM_ADDR_W-1:0] seg_base,
   input  logic [DATA_W-1:0]      seg_limit,
   input  logic                   xlat_en,
   output logic                   fault_pulse,
   // Read address and data
   output logic [GMEM_ADDR_W-1:0] araddr,
   output logic                   arvalid,
   input  logic                   arready,
   input  logic [DATA_W-1:0]      rdata,
   input  logic [1:0]             rresp,
   input  logic                   rvalid,
   output logic                   rready,
   // Write address, data and response
   output logic [GMEM_ADDR_W-1:0] awaddr,
   output logic                   awvalid,
   input  logic                   awready,
   output logic [DATA_W-1:0]      wdata,
   output logic [DATA_W/8-1:0]    wstrb,
   output logic                   wvalid,
   input  logic                   wready,
   input  logic [1:0]             bresp,
   input  logic                   bvalid,
   output logic                   bready
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_READ,
      S_WRITE,
      S_RESP,
      S_RETIRE
   } seq_state_t;

   seq_state_t             state;
   logic                   issue_en;
   logic                   req_push;
   mem_req_t               req_push_data;
   logic                   req_full;
   logic                   req_pop;
   mem_req_t               req_pop_data;
   logic                   req_empty;
   logic                   xl_stall;
   logic                   xl_valid;
   mem_req_t               xl_req;
   logic [GMEM_ADDR_W-1:0] xl_paddr;
   logic                   xl_fault;
   logic                   xl_is_load;
   mem_req_t               op_req;
   logic [GMEM_ADDR_W-1:0] op_paddr;
   logic                   op_fault;
   logic                   op_is_load;
   logic                   aw_done;
   logic                   w_done;
   logic                   aw_ok;
   logic                   w_ok;
   logic                   resp_done;
   logic [7:0]             lane_byte;
   logic [DATA_W-1:0]      load_word;
   logic [DATA_W-1:0]      res_data;
   logic                   res_fault;
   logic                   res_push;
   cdb_t                   res_push_data;
   logic                   res_full;
   logic                   res_pop;
   cdb_t                   res_pop_data;
   logic                   res_empty;

   // Hold off the core until the first cycle out of reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         issue_en <= 1'b0;
      end else begin
         issue_en <= 1'b1;
      end
   end

   assign ready         = issue_en && !req_full;
   assign req_push      = valid && ready;
   assign req_push_data = '{rsv_id: rsv_id, opcode: opcode, addr: address, data: data};

   op_fifo #(
      .payload_t (mem_req_t),
      .DEPTH     (QUEUE_DEPTH)
   ) req_fifo (
      .clk       (clk),
      .arst_n    (arst_n),
      .push      (req_push),
      .push_data (req_push_data),
      .full      (req_full),
      .pop       (req_pop),
      .pop_data  (req_pop_data),
      .empty     (req_empty)
   );

   // Translator only advances while the sequencer sits in idle
   assign xl_stall = (state != S_IDLE);
   assign req_pop  = !req_empty && (!xl_valid || !xl_stall);

   address_translator xlat (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (!req_empty),
      .in_req    (req_pop_data),
      .seg_base  (seg_base),
      .seg_limit (seg_limit),
      .xlat_en   (xlat_en),
      .stall     (xl_stall),
      .out_valid (xl_valid),
      .out_req   (xl_req),
      .out_paddr (xl_paddr),
      .out_fault (xl_fault)
   );

   assign xl_is_load = (xl_req.opcode == OP_LW) || (xl_req.opcode == OP_LBU);
   assign op_is_load = (op_req.opcode == OP_LW) || (op_req.opcode == OP_LBU);

   assign aw_ok     = aw_done || (awvalid && awready);
   assign w_ok      = w_done || (wvalid && wready);
   assign resp_done = op_fault || (rvalid && rready) || (bvalid && bready);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= S_IDLE;
         aw_done <= 1'b0;
         w_done  <= 1'b0;
      end else begin
         case (state)
            S_IDLE: begin
               if (xl_valid) begin
                  // A fault skips the bus but still passes through the response slot
                  if (xl_fault) begin
                     state <= S_RESP;
                  end else begin
                     state <= xl_is_load ? S_READ : S_WRITE;
                  end
               end
            end
            S_READ: begin
               if (arready) begin
                  state <= S_RESP;
               end
            end
            S_WRITE: begin
               if (aw_ok && w_ok) begin
                  state   <= S_RESP;
                  aw_done <= 1'b0;
                  w_done  <= 1'b0;
               end else begin
                  aw_done <= aw_ok;
                  w_done  <= w_ok;
               end
            end
            S_RESP: begin
               if (resp_done) begin
                  state <= S_RETIRE;
               end
            end
            S_RETIRE: begin
               if (!res_full) begin
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   assign lane_byte = rdata[{op_paddr[1:0], 3'b000} +: 8];
   assign load_word = (op_req.opcode == OP_LBU) ? {{(DATA_W-8){1'b0}}, lane_byte} : rdata;

   always_ff @(posedge clk) begin
      if (state == S_IDLE && xl_valid) begin
         op_req   <= xl_req;
         op_paddr <= xl_paddr;
         op_fault <= xl_fault;
      end
      if (state == S_RESP && resp_done) begin
         if (op_fault) begin
            res_data  <= '0;
            res_fault <= 1'b1;
         end else if (op_is_load) begin
            res_data  <= (rresp != 2'b00) ? '0 : load_word;
            res_fault <= (rresp != 2'b00);
         end else begin
            res_data  <= '0;
            res_fault <= (bresp != 2'b00);
         end
      end
   end

   // Bus addresses are word aligned; byte lanes go through wstrb and lane_byte
   assign araddr  = {op_paddr[GMEM_ADDR_W-1:2], 2'b00};
   assign arvalid = (state == S_READ);
   assign rready  = (state == S_RESP) && op_is_load && !op_fault;
   assign awaddr  = {op_paddr[GMEM_ADDR_W-1:2], 2'b00};
   assign awvalid = (state == S_WRITE) && !aw_done;
   assign wvalid  = (state == S_WRITE) && !w_done;
   assign wdata   = (op_req.opcode == OP_SB) ? {(DATA_W/8){op_req.data[7:0]}} : op_req.data;
   assign wstrb   = (op_req.opcode == OP_SB) ? (DATA_W/8)'(1) << op_paddr[1:0] : '1;
   assign bready  = (state == S_RESP) && !op_is_load && !op_fault;

   assign res_push      = (state == S_RETIRE) && !res_full;
   assign res_push_data = '{rsv_id: op_req.rsv_id, data: res_data, fault: res_fault};
   assign fault_pulse   = res_push && res_fault;

   op_fifo #(
      .payload_t (cdb_t),
      .DEPTH     (QUEUE_DEPTH)
   ) res_fifo (
      .clk       (clk),
      .arst_n    (arst_n),
      .push      (res_push),
      .push_data (res_push_data),
      .full      (res_full),
      .pop       (res_pop),
      .pop_data  (res_pop_data),
      .empty     (res_empty)
   );

   assign cdb_valid  = !res_empty;
   assign res_pop    = cdb_valid && cdb_ready;
   assign cdb_rsv_id = res_pop_data.rsv_id;
   assign cdb_data   = res_pop_data.data;
   assign cdb_fault  = res_pop_data.fault;

   a_ar_hold: assert property (
      @(posedge clk) disable iff (!arst_n)
      arvalid && !arready |=> arvalid && $stable(araddr)
   );

   a_aw_hold: assert property (
      @(posedge clk) disable iff (!arst_n)
      awvalid && !awready |=> awvalid && $stable(awaddr)
   );

   a_w_hold: assert property (
      @(posedge clk) disable iff (!arst_n)
      wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb)
   );

   // Result outputs hold while the core back-pressures the CDB
   a_cdb_hold: assert property (
      @(posedge clk) disable iff (!arst_n)
      cdb_valid && !cdb_ready |=> cdb_valid && $stable({cdb_rsv_id, cdb_data, cdb_fault})
   );

endmodule

`default_nettype wire

/* hdl/fcpu.sv */
`timescale 1ns/100ps
`default_nettype none

module fcpu
   import fcpu_pkg::*;
#(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                   clk,
   input  logic                   arst_n,
   // Issue port from the core
   input  logic [RSV_ID_W-1:0]    rsv_id,
   input  logic                   valid,
   input  mem_op_t                opcode,
   input  logic [DATA_W-1:0]      address,
   input  logic [DATA_W-1:0]      data,
   output logic                   ready,
   // Common data bus
   output logic [RSV_ID_W-1:0]    cdb_rsv_id,
   output logic [DATA_W-1:0]      cdb_data,
   output logic                   cdb_fault,
   output logic                   cdb_valid,
   input  logic                   cdb_ready,
   // Configuration
   input  logic                   cfg_we,
   input  cfg_addr_t              cfg_addr,
   input  logic [DATA_W-1:0]      cfg_wdata,
   output logic [DATA_W-1:0]      cfg_rdata,
   // Read channels
   output logic [GMEM_ADDR_W-1:0] araddr,
   output logic                   arvalid,
   input  logic                   arready,
   input  logic [DATA_W-1:0]      rdata,
   input  logic [1:0]             rresp,
   input  logic                   rvalid,
   output logic                   rready,
   // Write channels
   output logic [GMEM_ADDR_W-1:0] awaddr,
   output logic                   awvalid,
   input  logic                   awready,
   output logic [DATA_W-1:0]      wdata,
   output logic [DATA_W/8-1:0]    wstrb,
   output logic                   wvalid,
   input  logic                   wready,
   input  logic [1:0]             bresp,
   input  logic                   bvalid,
   output logic                   bready
);

   logic [GMEM_ADDR_W-1:0] seg_base;
   logic [DATA_W-1:0]      seg_limit;
   logic                   xlat_en;
   logic                   fault_pulse;

   mmu_cfg_regs cfg_inst (
      .*
   );

   memory_management_unit #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) mmu_inst (
      .*
   );

endmodule

`default_nettype wire

/* dv/axi_mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_mem_model #(
   parameter int WORDS = 1024
) (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        stall,
   input  logic [31:0] araddr,
   input  logic        arvalid,
   output logic        arready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rvalid,
   input  logic        rready,
   input  logic [31:0] awaddr,
   input  logic        awvalid,
   output logic        awready,
   input  logic [31:0] wdata,
   input  logic [3:0]  wstrb,
   input  logic        wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  logic        bready
);

   logic [31:0] mem [WORDS];
   logic        aw_got;
   logic        w_got;
   logic [31:0] aw_addr_q;
   logic [31:0] w_data_q;
   logic [3:0]  w_strb_q;
   logic        aw_now;
   logic        w_now;
   logic [31:0] wr_addr;
   logic [31:0] wr_data;
   logic [3:0]  wr_strb;

   assign arready = !stall && !rvalid;
   assign awready = !stall && !aw_got && !bvalid;
   assign wready  = !stall && !w_got && !bvalid;
   assign aw_now  = awvalid && awready;
   assign w_now   = wvalid && wready;
   assign wr_addr = aw_got ? aw_addr_q : awaddr;
   assign wr_data = w_got ? w_data_q : wdata;
   assign wr_strb = w_got ? w_strb_q : wstrb;

   // Address and data may arrive in different cycles
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < WORDS; i++) begin
            mem[i] <= '0;
         end
         aw_got    <= 1'b0;
         w_got     <= 1'b0;
         aw_addr_q <= '0;
         w_data_q  <= '0;
         w_strb_q  <= '0;
         bvalid    <= 1'b0;
         bresp     <= 2'b00;
      end else begin
         if (bvalid && bready) begin
            bvalid <= 1'b0;
         end
         if ((aw_got || aw_now) && (w_got || w_now)) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            bvalid <= 1'b1;
            bresp  <= wr_addr[15] ? 2'b10 : 2'b00;
            if (!wr_addr[15]) begin
               for (int b = 0; b < 4; b++) begin
                  if (wr_strb[b]) begin
                     mem[wr_addr[11:2]][8*b +: 8] <= wr_data[8*b +: 8];
                  end
               end
            end
         end else begin
            if (aw_now) begin
               aw_got    <= 1'b1;
               aw_addr_q <= awaddr;
            end
            if (w_now) begin
               w_got    <= 1'b1;
               w_data_q <= wdata;
               w_strb_q <= wstrb;
            end
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rvalid <= 1'b0;
         rdata  <= '0;
         rresp  <= 2'b00;
      end else if (arvalid && arready) begin
         rvalid <= 1'b1;
         // Bit 15 marks a hole in the address map
         rresp  <= araddr[15] ? 2'b10 : 2'b00;
         rdata  <= araddr[15] ? '0 : mem[araddr[11:2]];
      end else if (rvalid && rready) begin
         rvalid <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* dv/fcpu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module fcpu_tb
   import fcpu_pkg::*;
();

   localparam int QUEUE_DEPTH = 4;
   localparam int TIMEOUT_CYCLES = 2000;

   logic                   clk = 1'b0;
   logic                   arst_n;
   logic [RSV_ID_W-1:0]    rsv_id;
   logic                   valid;
   mem_op_t                opcode;
   logic [DATA_W-1:0]      address;
   logic [DATA_W-1:0]      data;
   logic                   ready;
   logic [RSV_ID_W-1:0]    cdb_rsv_id;
   logic [DATA_W-1:0]      cdb_data;
   logic                   cdb_fault;
   logic                   cdb_valid;
   logic                   cdb_ready;
   logic                   cfg_we;
   cfg_addr_t              cfg_addr;
   logic [DATA_W-1:0]      cfg_wdata;
   logic [DATA_W-1:0]      cfg_rdata;
   logic [GMEM_ADDR_W-1:0] araddr;
   logic                   arvalid;
   logic                   arready;
   logic [DATA_W-1:0]      rdata;
   logic [1:0]             rresp;
   logic                   rvalid;
   logic                   rready;
   logic [GMEM_ADDR_W-1:0] awaddr;
   logic                   awvalid;
   logic                   awready;
   logic [DATA_W-1:0]      wdata;
   logic [DATA_W/8-1:0]    wstrb;
   logic                   wvalid;
   logic                   wready;
   logic [1:0]             bresp;
   logic                   bvalid;
   logic                   bready;
   logic                   mem_stall;

   logic [31:0] lfsr = 32'd87082;
   logic        rand_mode = 1'b0;
   logic        hold_cdb = 1'b0;
   logic        saw_full = 1'b0;
   cdb_t        exp_q[$];
   cdb_t        exp_head;
   logic        exp_avail = 1'b0;
   logic [31:0] shadow [1024];
   logic        sh_xlat = 1'b0;
   logic [31:0] sh_base = '0;
   logic [31:0] sh_limit = '0;
   int          sh_faults = 0;
   int          err_cnt = 0;
   int          err_mark = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   always #10 clk = ~clk;

   fcpu #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) uut (
      .*
   );

   axi_mem_model mem_model (
      .*,
      .stall (mem_stall)
   );

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   always @(negedge clk) begin
      if (rand_mode) begin
         lfsr = lfsr_next(lfsr);
         mem_stall = lfsr[0];
         lfsr = lfsr_next(lfsr);
         cdb_ready = !hold_cdb && lfsr[0];
      end else begin
         mem_stall = 1'b0;
         cdb_ready = !hold_cdb;
      end
   end

   // Expected result from the translation and byte lane rules
   function automatic cdb_t predict(input logic [3:0] tag, input mem_op_t op,
                                    input logic [31:0] va, input logic [31:0] wd);
      logic [31:0] pa;
      logic        bad;
      logic [9:0]  idx;
      cdb_t        r;
      pa  = sh_xlat ? sh_base + va : va;
      bad = (sh_xlat && va >= sh_limit) || pa[15] ||
            ((op == OP_LW || op == OP_SW) && va[1:0] != 2'b00);
      idx = pa[11:2];
      r   = '{rsv_id: tag, data: '0, fault: bad};
      if (bad) begin
         sh_faults++;
      end else begin
         case (op)
            OP_LW:  r.data = shadow[idx];
            OP_LBU: r.data = {24'h0, shadow[idx][pa[1:0]*8 +: 8]};
            OP_SW:  shadow[idx] = wd;
            OP_SB:  shadow[idx][pa[1:0]*8 +: 8] = wd[7:0];
            default: r.fault = 1'b1;
         endcase
      end
      return r;
   endfunction

   task automatic refresh_head();
      exp_avail = (exp_q.size() > 0);
      if (exp_avail) begin
         exp_head = exp_q[0];
      end
   endtask

   always @(posedge clk) begin
      if ($sampled(arst_n && cdb_valid && cdb_ready) && exp_q.size() > 0) begin
         void'(exp_q.pop_front());
         refresh_head();
      end
   end

   a_cdb_result: assert property (
      @(posedge clk) disable iff (!arst_n)
      cdb_valid && cdb_ready |-> exp_avail && cdb_rsv_id == exp_head.rsv_id &&
         cdb_data == exp_head.data && cdb_fault == exp_head.fault
   ) else begin
      err_cnt++;
      $display("Error at %0t: CDB tag %0d data %08h fault %0b, expected tag %0d data %08h fault %0b",
               $time, $sampled(cdb_rsv_id), $sampled(cdb_data), $sampled(cdb_fault),
               $sampled(exp_head.rsv_id), $sampled(exp_head.data), $sampled(exp_head.fault));
   end

   a_no_extra: assert property (
      @(posedge clk) disable iff (!arst_n) cdb_valid |-> exp_avail
   ) else begin
      err_cnt++;
      $display("Error at %0t: CDB result with no operation outstanding", $time);
   end

   // First edge after reset release still shows the reset values
   a_reset_quiet: assert property (
      @(posedge clk) $rose(arst_n) |->
         !ready && !cdb_valid && !arvalid && !awvalid && !wvalid && !uut.fault_pulse
   ) else begin
      err_cnt++;
      $display("Error at %0t: output high right after reset", $time);
   end

   task automatic abort_on_timeout(input string what);
      $display("Timeout at %0t while waiting for %s", $time, what);
      $display("Result: FAILED");
      $finish;
   endtask

   task automatic issue_op(input logic [3:0] tag, input mem_op_t op,
                           input logic [31:0] va, input logic [31:0] wd);
      int waited;
      rsv_id  = tag;
      opcode  = op;
      address = va;
      data    = wd;
      valid   = 1'b1;
      waited  = 0;
      while (!ready) begin
         if (hold_cdb) begin
            saw_full = 1'b1;
            hold_cdb <= 1'b0;
         end
         if (waited == TIMEOUT_CYCLES) begin
            abort_on_timeout("issue ready");
         end
         waited++;
         @(negedge clk);
      end
      @(posedge clk);
      exp_q.push_back(predict(tag, op, va, wd));
      refresh_head();
      @(negedge clk);
      valid = 1'b0;
   endtask

   task automatic wait_results();
      int waited;
      waited = 0;
      while (exp_q.size() > 0) begin
         if (waited == TIMEOUT_CYCLES) begin
            abort_on_timeout("outstanding CDB results");
         end
         waited++;
         @(negedge clk);
      end
   endtask

   task automatic write_cfg(input cfg_addr_t a, input logic [31:0] v);
      cfg_addr  = a;
      cfg_wdata = v;
      cfg_we    = 1'b1;
      @(negedge clk);
      cfg_we = 1'b0;
      case (a)
         REG_CTRL:   sh_xlat = v[0];
         REG_BASE:   sh_base = v;
         REG_LIMIT:  sh_limit = v;
         REG_FAULTS: sh_faults = 0;
         default:    sh_faults = sh_faults;
      endcase
   endtask

   task automatic check_reg(input cfg_addr_t a, input logic [31:0] exp_val, input string what);
      cfg_addr = a;
      @(negedge clk);
      assert (cfg_rdata == exp_val) else begin
         err_cnt++;
         $display("Error at %0t: %s reads %08h, expected %08h", $time, what, cfg_rdata, exp_val);
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (err_cnt == err_mark) begin
         $display("Test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: failed with %0d errors", tests_run, name, err_cnt - err_mark);
      end
      err_mark = err_cnt;
   endtask

   initial begin
      mem_op_t op;
      logic [31:0] va;
      for (int i = 0; i < 1024; i++) begin
         shadow[i] = '0;
      end
      arst_n    = 1'b0;
      valid     = 1'b0;
      rsv_id    = '0;
      opcode    = OP_LW;
      address   = '0;
      data      = '0;
      cdb_ready = 1'b1;
      cfg_we    = 1'b0;
      cfg_addr  = REG_CTRL;
      cfg_wdata = '0;
      mem_stall = 1'b0;
      repeat (5) @(negedge clk);
      arst_n = 1'b1;
      repeat (2) @(negedge clk);

      for (int i = 0; i < 4; i++) begin
         issue_op(4'(i), OP_SW, 32'(i * 4), 32'hA500_0000 + 32'(i) * 32'h0101_0101);
      end
      for (int i = 0; i < 4; i++) begin
         issue_op(4'(i + 4), OP_LW, 32'(i * 4), '0);
      end
      wait_results();
      finish_test("word store and load");

      for (int b = 0; b < 4; b++) begin
         issue_op(4'(b), OP_SB, 32'h40 + 32'(b), 32'(8'h11 * (b + 1)));
      end
      for (int b = 0; b < 4; b++) begin
         issue_op(4'(b + 4), OP_LBU, 32'h40 + 32'(b), '0);
      end
      issue_op(4'd8, OP_LW, 32'h40, '0);
      wait_results();
      finish_test("byte lanes");

      issue_op(4'd1, OP_SW, 32'h120, 32'hFEED_0120);
      wait_results();
      write_cfg(REG_BASE, 32'h100);
      write_cfg(REG_LIMIT, 32'h80);
      write_cfg(REG_CTRL, 32'h1);
      check_reg(REG_BASE, 32'h100, "segment base");
      check_reg(REG_LIMIT, 32'h80, "segment limit");
      check_reg(REG_CTRL, 32'h1, "translation enable");
      issue_op(4'd2, OP_LW, 32'h20, '0);
      issue_op(4'd3, OP_LW, 32'h80, '0);
      issue_op(4'd4, OP_SW, 32'h90, 32'h1234_5678);
      wait_results();
      check_reg(REG_FAULTS, 32'(sh_faults), "fault counter");
      write_cfg(REG_FAULTS, '0);
      check_reg(REG_FAULTS, 32'h0, "cleared fault counter");
      write_cfg(REG_CTRL, 32'h0);
      finish_test("segment translation");

      issue_op(4'd5, OP_SW, 32'h60, 32'hCAFE_0060);
      issue_op(4'd6, OP_LW, 32'h62, '0);
      issue_op(4'd7, OP_SW, 32'h61, 32'hDEAD_BEEF);
      issue_op(4'd8, OP_LW, 32'h60, '0);
      wait_results();
      finish_test("misaligned word access");

      // CDB held off until the issue port backs up
      rand_mode <= 1'b1;
      hold_cdb  <= 1'b1;
      @(negedge clk);
      for (int i = 0; i < 12; i++) begin
         op = mem_op_t'(i % 4);
         va = 32'h200 + 32'((i % 3) * 4);
         if (op == OP_SB || op == OP_LBU) begin
            va = va + 32'((i / 4) % 4);
         end
         issue_op(4'(i), op, va, 32'hC0DE_0000 + 32'(i) * 32'h1111);
      end
      wait_results();
      assert (saw_full) else begin
         err_cnt++;
         $display("Issue port never stalled while the queues were full");
      end
      finish_test("random back-pressure burst");

      write_cfg(REG_FAULTS, '0);
      issue_op(4'd9, OP_SW, 32'h8000, 32'h5555_AAAA);
      issue_op(4'd10, OP_LW, 32'h8004, '0);
      issue_op(4'd11, OP_LBU, 32'h8001, '0);
      issue_op(4'd12, OP_SB, 32'h8002, 32'h77);
      issue_op(4'd13, OP_LW, 32'h200, '0);
      wait_results();
      check_reg(REG_FAULTS, 32'(sh_faults), "bus error fault counter");
      finish_test("bus error response");

      $display("Tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
      if (err_cnt == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
hdl/fcpu_pkg.sv
hdl/op_fifo.sv
hdl/mmu_cfg_regs.sv
hdl/address_translator.sv
hdl/memory_management_unit.sv
hdl/fcpu.sv
dv/axi_mem_model.sv
dv/fcpu_tb.sv

/* Bender.yml */
package:
  name: fcpu

sources:
  - files:
      - hdl/fcpu_pkg.sv
      - hdl/op_fifo.sv
      - hdl/mmu_cfg_regs.sv
      - hdl/address_translator.sv
      - hdl/memory_management_unit.sv
      - hdl/fcpu.sv
  - target: test
    files:
      - dv/axi_mem_model.sv
      - dv/fcpu_tb.sv
